// File: hart.f
+incdir+source
source/isa_pkg.sv
source/hart_pkg.sv
source/control_decode.sv
source/alu_decode.sv
source/imm_gen.sv
source/reg_file.sv
source/execute_unit.sv
source/pc_unit.sv
source/hart.sv
tests/hart_tb.sv

// File: source/alu_decode.sv
`timescale 1ns/1ps

module alu_decode (
    input  hart_pkg::alu_class_e i_alu_class,
    input  logic [2:0]           i_funct3,
    input  logic [6:0]           i_funct7,
    output hart_pkg::alu_ctrl_t  o_alu_ctrl
);

    always_comb begin
        o_alu_ctrl.op           = hart_pkg::ALU_ADD;
        o_alu_ctrl.cmp_unsigned = 1'b0;

        if (i_alu_class == hart_pkg::BRANCH_CMP) begin
            // branches subtract and only the unsigned pair changes the compare
            o_alu_ctrl.op           = hart_pkg::ALU_SUB;
            o_alu_ctrl.cmp_unsigned = (i_funct3 == isa_pkg::BLTU) ||
                                      (i_funct3 == isa_pkg::BGEU);
        end else begin
            case (isa_pkg::alu_funct_e'(i_funct3))
                isa_pkg::ADD: begin
                    // addi has no sub form, its bit 30 belongs to the immediate
                    if (i_alu_class == hart_pkg::REG && i_funct7[5]) begin
                        o_alu_ctrl.op = hart_pkg::ALU_SUB;
                    end else begin
                        o_alu_ctrl.op = hart_pkg::ALU_ADD;
                    end
                end
                isa_pkg::SLL:  o_alu_ctrl.op = hart_pkg::ALU_SLL;
                isa_pkg::SLT:  o_alu_ctrl.op = hart_pkg::ALU_SLT;
                isa_pkg::SLTU: begin
                    o_alu_ctrl.op           = hart_pkg::ALU_SLTU;
                    o_alu_ctrl.cmp_unsigned = 1'b1;
                end
                isa_pkg::XOR:  o_alu_ctrl.op = hart_pkg::ALU_XOR;
                isa_pkg::SR: begin
                    // srai keeps the same funct7 bit as sra
                    o_alu_ctrl.op = i_funct7[5] ? hart_pkg::ALU_SRA : hart_pkg::ALU_SRL;
                end
                isa_pkg::OR:   o_alu_ctrl.op = hart_pkg::ALU_OR;
                isa_pkg::AND:  o_alu_ctrl.op = hart_pkg::ALU_AND;
                default:       o_alu_ctrl.op = hart_pkg::ALU_ADD;
            endcase
        end
    end

endmodule

// File: source/control_decode.sv
`timescale 1ns/1ps

module control_decode (
    input  logic [6:0]      i_opcode,
    output hart_pkg::ctrl_t o_ctrl
);

    always_comb begin
        // everything off unless the opcode is one we execute
        // unknown opcodes fall through and retire as a no-op
        o_ctrl = '0;
        o_ctrl.wb_sel    = hart_pkg::WB_ALU;
        o_ctrl.imm_fmt   = isa_pkg::NONE;
        o_ctrl.alu_class = hart_pkg::BRANCH_CMP;

        case (isa_pkg::opcode_e'(i_opcode))
            isa_pkg::OP: begin
                // both operands come from the register file
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_sel    = hart_pkg::WB_ALU;
                o_ctrl.alu_class = hart_pkg::REG;
            end
            isa_pkg::OP_IMM: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.wb_sel      = hart_pkg::WB_ALU;
                o_ctrl.imm_fmt     = isa_pkg::I;
                o_ctrl.alu_class   = hart_pkg::IMM;
            end
            isa_pkg::LUI: begin
                // the U immediate goes straight to rd and the ALU is unused
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_sel    = hart_pkg::WB_IMM;
                o_ctrl.imm_fmt   = isa_pkg::U;
            end
            isa_pkg::BRANCH: begin
                // rs1 and rs2 are compared, the immediate is the pc offset
                o_ctrl.branch    = 1'b1;
                o_ctrl.imm_fmt   = isa_pkg::B;
                o_ctrl.alu_class = hart_pkg::BRANCH_CMP;
            end
            isa_pkg::JAL: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.jump      = 1'b1;
                o_ctrl.wb_sel    = hart_pkg::WB_LINK;
                o_ctrl.imm_fmt   = isa_pkg::J;
            end
            default: begin
                o_ctrl.reg_write = 1'b0;
            end
        endcase
    end

endmodule

// File: source/execute_unit.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module execute_unit (
    input  hart_pkg::ctrl_t       i_ctrl,
    input  hart_pkg::alu_ctrl_t   i_alu_ctrl,
    input  logic [`HART_XLEN-1:0] i_rs1_data,
    input  logic [`HART_XLEN-1:0] i_rs2_data,
    input  logic [`HART_XLEN-1:0] i_imm,
    input  logic [`HART_XLEN-1:0] i_link,
    output logic                  o_eq,
    output logic                  o_lt,
    output logic [`HART_XLEN-1:0] o_rd_wdata
);

    logic [`HART_XLEN-1:0] op_a;
    logic [`HART_XLEN-1:0] op_b;
    logic [4:0]            shamt;
    logic [`HART_XLEN-1:0] result;

    //////////////////////////////////////////////////////////////////////
    // operands and compare flags
    //////////////////////////////////////////////////////////////////////

    assign op_a  = i_rs1_data;
    assign op_b  = i_ctrl.alu_src_imm ? i_imm : i_rs2_data;
    // only the low five bits count, so shamt in slli and srai works the same
    assign shamt = op_b[4:0];

    // the branch resolver and slt both read these flags
    assign o_eq = (op_a == op_b);
    assign o_lt = i_alu_ctrl.cmp_unsigned ? (op_a < op_b)
                                          : ($signed(op_a) < $signed(op_b));

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_alu_ctrl.op)
            hart_pkg::ALU_ADD:  result = op_a + op_b;
            hart_pkg::ALU_SUB:  result = op_a - op_b;
            hart_pkg::ALU_SLL:  result = op_a << shamt;
            // the compare is already signed or unsigned as decoded
            hart_pkg::ALU_SLT:  result = {{(`HART_XLEN-1){1'b0}}, o_lt};
            hart_pkg::ALU_SLTU: result = {{(`HART_XLEN-1){1'b0}}, o_lt};
            hart_pkg::ALU_XOR:  result = op_a ^ op_b;
            hart_pkg::ALU_SRL:  result = op_a >> shamt;
            hart_pkg::ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
            hart_pkg::ALU_OR:   result = op_a | op_b;
            hart_pkg::ALU_AND:  result = op_a & op_b;
            default:            result = op_a + op_b;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // writeback select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_ctrl.wb_sel)
            hart_pkg::WB_IMM:  o_rd_wdata = i_imm;
            hart_pkg::WB_LINK: o_rd_wdata = i_link;
            default:           o_rd_wdata = result;
        endcase
    end

endmodule

// File: source/hart.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module hart (
    input  logic                  i_clk,
    input  logic                  i_reset,
    output logic [`HART_XLEN-1:0] o_imem_raddr,
    input  logic [`HART_XLEN-1:0] i_imem_rdata,
    output hart_pkg::retire_t     o_retire
);

    hart_pkg::ctrl_t       ctrl;
    hart_pkg::alu_ctrl_t   alu_ctrl;
    logic [`HART_XLEN-1:0] imm;
    logic [`HART_XLEN-1:0] rs1_data;
    logic [`HART_XLEN-1:0] rs2_data;
    logic [`HART_XLEN-1:0] pc;
    logic [`HART_XLEN-1:0] link;
    logic [`HART_XLEN-1:0] next_pc;
    logic                  eq;
    logic                  lt;
    logic [`HART_XLEN-1:0] rd_wdata;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    // the fetched word is used in the same cycle, nothing is latched
    assign o_imem_raddr = pc;

    control_decode control_decode_inst (
        .i_opcode (i_imem_rdata[6:0]),
        .o_ctrl   (ctrl)
    );

    alu_decode alu_decode_inst (
        .i_alu_class (ctrl.alu_class),
        .i_funct3    (i_imem_rdata[14:12]),
        .i_funct7    (i_imem_rdata[31:25]),
        .o_alu_ctrl  (alu_ctrl)
    );

    imm_gen imm_gen_inst (
        .i_inst (i_imem_rdata),
        .i_fmt  (ctrl.imm_fmt),
        .o_imm  (imm)
    );

    //////////////////////////////////////////////////////////////////////
    // register read, execute and next pc
    //////////////////////////////////////////////////////////////////////

    reg_file reg_file_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rs1_raddr (i_imem_rdata[19:15]),
        .i_rs2_raddr (i_imem_rdata[24:20]),
        .o_rs1_rdata (rs1_data),
        .o_rs2_rdata (rs2_data),
        .i_rd_wen    (ctrl.reg_write),
        .i_rd_waddr  (i_imem_rdata[11:7]),
        .i_rd_wdata  (rd_wdata)
    );

    execute_unit execute_unit_inst (
        .i_ctrl     (ctrl),
        .i_alu_ctrl (alu_ctrl),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_imm      (imm),
        .i_link     (link),
        .o_eq       (eq),
        .o_lt       (lt),
        .o_rd_wdata (rd_wdata)
    );

    pc_unit pc_unit_inst (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_ctrl    (ctrl),
        .i_funct3  (i_imem_rdata[14:12]),
        .i_eq      (eq),
        .i_lt      (lt),
        .i_imm     (imm),
        .o_pc      (pc),
        .o_link    (link),
        .o_next_pc (next_pc)
    );

    //////////////////////////////////////////////////////////////////////
    // retire
    //////////////////////////////////////////////////////////////////////

    // single cycle, so every cycle out of reset retires one instruction
    always_comb begin
        o_retire.valid    = !i_reset;
        o_retire.inst     = i_imem_rdata;
        o_retire.pc       = pc;
        o_retire.next_pc  = next_pc;
        // branches and no-ops report rd as x0
        o_retire.rd_waddr = ctrl.reg_write ? i_imem_rdata[11:7] : '0;
        o_retire.rd_wdata = rd_wdata;
    end

endmodule

// File: source/hart_consts.svh
`ifndef HART_CONSTS_SVH
`define HART_CONSTS_SVH

// width of the data path, the pc and every register
`define HART_XLEN 32

// number of architectural integer registers, x0 included
`define HART_NUM_REGS 32

// bits needed to address one register
`define HART_REG_AW 5

// first instruction address after reset
`define HART_RESET_ADDR 32'h0000_0000

// every instruction is one word long
`define HART_INST_STEP 32'd4

`endif

// File: source/hart_pkg.sv
`include "hart_consts.svh"

package hart_pkg;

    // operation carried out by the ALU
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // source of the value written to rd
    typedef enum logic [1:0] {
        WB_ALU, WB_IMM, WB_LINK
    } wb_sel_e;

    // tells the ALU decoder how to read funct3 and funct7
    typedef enum logic [1:0] {
        BRANCH_CMP, REG, IMM
    } alu_class_e;

    // controls produced from the opcode alone
    typedef struct packed {
        logic                  reg_write;
        logic                  alu_src_imm;
        logic                  branch;
        logic                  jump;
        wb_sel_e               wb_sel;
        isa_pkg::imm_format_e  imm_fmt;
        alu_class_e            alu_class;
    } ctrl_t;

    typedef struct packed {
        alu_op_e op;
        logic    cmp_unsigned;
    } alu_ctrl_t;

    // one retired instruction, reported in the cycle it executes
    typedef struct packed {
        logic                     valid;
        logic [`HART_XLEN-1:0]    inst;
        logic [`HART_XLEN-1:0]    pc;
        logic [`HART_XLEN-1:0]    next_pc;
        logic [`HART_REG_AW-1:0]  rd_waddr;
        logic [`HART_XLEN-1:0]    rd_wdata;
    } retire_t;

endpackage

// File: source/imm_gen.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module imm_gen (
    input  logic [`HART_XLEN-1:0] i_inst,
    input  isa_pkg::imm_format_e  i_fmt,
    output logic [`HART_XLEN-1:0] o_imm
);

    // bit 31 is always the sign, whatever the format
    always_comb begin
        case (i_fmt)
            isa_pkg::I: o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
            isa_pkg::U: o_imm = {i_inst[31:12], 12'b0};
            isa_pkg::B: begin
                // branch offsets are in halfwords so bit 0 is implied zero
                o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                         i_inst[30:25], i_inst[11:8], 1'b0};
            end
            isa_pkg::J: begin
                o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                         i_inst[20], i_inst[30:21], 1'b0};
            end
            default: o_imm = '0;
        endcase
    end

endmodule

// File: source/isa_pkg.sv
package isa_pkg;

    // major opcodes of the supported base integer subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // funct3 field of a conditional branch
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_cond_e;

    // funct3 field of the register and immediate ALU instructions
    // SR covers both srl and sra, funct7 bit 5 tells them apart
    typedef enum logic [2:0] {
        ADD  = 3'b000,
        SLL  = 3'b001,
        SLT  = 3'b010,
        SLTU = 3'b011,
        XOR  = 3'b100,
        SR   = 3'b101,
        OR   = 3'b110,
        AND  = 3'b111
    } alu_funct_e;

    // layout of the immediate inside the instruction word
    typedef enum logic [2:0] {
        NONE = 3'd0,
        I    = 3'd1,
        U    = 3'd2,
        B    = 3'd3,
        J    = 3'd4
    } imm_format_e;

endpackage

// File: source/pc_unit.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module pc_unit (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  hart_pkg::ctrl_t       i_ctrl,
    input  logic [2:0]            i_funct3,
    input  logic                  i_eq,
    input  logic                  i_lt,
    input  logic [`HART_XLEN-1:0] i_imm,
    output logic [`HART_XLEN-1:0] o_pc,
    output logic [`HART_XLEN-1:0] o_link,
    output logic [`HART_XLEN-1:0] o_next_pc
);

    logic cond_true;
    logic taken;

    // lt already carries the signed or unsigned sense for the condition
    always_comb begin
        case (isa_pkg::branch_cond_e'(i_funct3))
            isa_pkg::BEQ:  cond_true = i_eq;
            isa_pkg::BNE:  cond_true = !i_eq;
            isa_pkg::BLT:  cond_true = i_lt;
            isa_pkg::BGE:  cond_true = !i_lt;
            isa_pkg::BLTU: cond_true = i_lt;
            isa_pkg::BGEU: cond_true = !i_lt;
            default:       cond_true = 1'b0;
        endcase
    end

    assign taken     = i_ctrl.branch && cond_true;
    assign o_link    = o_pc + `HART_INST_STEP;
    assign o_next_pc = (i_ctrl.jump || taken) ? (o_pc + i_imm) : o_link;

    // held at the reset address for as long as reset stays high
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pc <= `HART_RESET_ADDR;
        end else begin
            o_pc <= o_next_pc;
        end
    end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module reg_file (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [`HART_REG_AW-1:0] i_rs1_raddr,
    input  logic [`HART_REG_AW-1:0] i_rs2_raddr,
    output logic [`HART_XLEN-1:0]   o_rs1_rdata,
    output logic [`HART_XLEN-1:0]   o_rs2_rdata,
    input  logic                    i_rd_wen,
    input  logic [`HART_REG_AW-1:0] i_rd_waddr,
    input  logic [`HART_XLEN-1:0]   i_rd_wdata
);

    logic [`HART_XLEN-1:0] regs [`HART_NUM_REGS];

    // x0 is never written, so a write to it simply disappears
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `HART_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_waddr != '0)) begin
            regs[i_rd_waddr] <= i_rd_wdata;
        end
    end

    // reads are combinational and see the old value during a write cycle
    assign o_rs1_rdata = (i_rs1_raddr == '0) ? '0 : regs[i_rs1_raddr];
    assign o_rs2_rdata = (i_rs2_raddr == '0) ? '0 : regs[i_rs2_raddr];

endmodule

// File: tests/hart_tb.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module hart_tb;

    localparam int reset_cycles   = 16;
    localparam int inst_per_test  = 200;
    localparam int num_tests      = 6;
    localparam int timeout_cycles = reset_cycles + num_tests * inst_per_test + 100;

    logic              i_clk;
    logic              i_reset;
    logic [31:0]       o_imem_raddr;
    logic [31:0]       i_imem_rdata;
    hart_pkg::retire_t retire;

    logic [31:0] rng_state;
    logic [31:0] model_pc;
    logic [31:0] model_regs [32];
    int          cycle_count;
    int          check_count;
    int          error_count;

    hart hart_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .o_imem_raddr (o_imem_raddr),
        .i_imem_rdata (i_imem_rdata),
        .o_retire     (retire)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // the run is bounded by the total length of all tests plus a margin
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // funct7 bit 5 is only legal for add/sub and the right shifts
    function automatic logic [31:0] r_type_inst();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = next_rand();
        f3 = r[2:0];
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[3]) ? 7'b0100000 : 7'b0000000;
        return {f7, r[8:4], r[13:9], f3, r[18:14], 7'b0110011};
    endfunction

    // addi with a random source and immediate spreads values over the registers
    function automatic logic [31:0] seed_inst();
        logic [31:0] r;
        r = next_rand();
        return {r[31:20], r[19:15], 3'b000, r[11:7], 7'b0010011};
    endfunction

    function automatic logic [31:0] i_type_inst();
        logic [31:0] r;
        logic [11:0] imm;
        r = next_rand();
        // one in sixteen is lui, the rest cover every OP_IMM funct3
        if (r[31:29] == 3'd0 && r[28]) begin
            r = next_rand();
            return {r[31:12], r[11:7], 7'b0110111};
        end
        if (r[14:12] == 3'd1) begin
            imm = {7'b0, r[24:20]};
        end else if (r[14:12] == 3'd5) begin
            imm = {1'b0, r[30], 5'b0, r[24:20]};
        end else begin
            imm = r[31:20];
        end
        return {imm, r[19:15], r[14:12], r[11:7], 7'b0010011};
    endfunction

    // offsets stay word aligned so no target is misaligned
    function automatic logic [31:0] branch_inst();
        logic [31:0] r;
        logic [12:0] off;
        logic [2:0]  f3;
        logic [4:0]  rs2;
        r   = next_rand();
        off = {r[31:21], 2'b00};
        f3  = (r[2:0] % 6 < 2) ? r[2:0] % 6 : r[2:0] % 6 + 2;
        // equal operands now and then so that beq and bge see equality
        rs2 = (r[5:4] == 2'd0) ? r[10:6] : r[15:11];
        return {off[12], off[10:5], rs2, r[10:6], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_inst();
        logic [31:0] r;
        logic [20:0] off;
        r   = next_rand();
        off = {r[31:13], 2'b00};
        return {off[20], off[10:1], off[11], off[19:12], r[11:7], 7'b1101111};
    endfunction

    function automatic logic [31:0] unsupported_inst();
        logic [31:0] r;
        r = next_rand();
        while (r[6:0] == 7'h33 || r[6:0] == 7'h13 || r[6:0] == 7'h37 ||
               r[6:0] == 7'h63 || r[6:0] == 7'h6f) begin
            r = next_rand();
        end
        return r;
    endfunction

    function automatic logic [31:0] make_inst(input int test_id);
        logic [31:0] pick;
        pick = next_rand();
        case (test_id)
            0: return r_type_inst();
            1: return (pick[1:0] == 2'd0) ? seed_inst() : r_type_inst();
            2: return i_type_inst();
            3: return (pick[1:0] == 2'd0) ? seed_inst() : branch_inst();
            4: return (pick[1:0] == 2'd0) ? seed_inst() : jal_inst();
            // R-type reads in between expose any register a no-op disturbed
            default: return (pick[1:0] == 2'd0) ? r_type_inst() : unsupported_inst();
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            error_count++;
        end
    endtask

    // computes the retire fields for inst at the model pc, checks, then commits
    task automatic step_model(input logic [31:0] inst);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] exp_next;
        logic [31:0] exp_wdata;
        logic        wr;
        logic        taken;
        a         = model_regs[inst[19:15]];
        b         = model_regs[inst[24:20]];
        imm_i     = {{20{inst[31]}}, inst[31:20]};
        imm_b     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        exp_next  = model_pc + 32'd4;
        exp_wdata = '0;
        wr        = 1'b0;
        case (inst[6:0])
            7'h33: begin
                wr        = 1'b1;
                exp_wdata = alu_result(inst[14:12], inst[30], a, b);
            end
            7'h13: begin
                wr        = 1'b1;
                // addi has no subtract form, so bit 30 only matters for srai
                exp_wdata = alu_result(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, imm_i);
            end
            7'h37: begin
                wr        = 1'b1;
                exp_wdata = {inst[31:12], 12'b0};
            end
            7'h63: begin
                case (inst[14:12])
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) exp_next = model_pc + imm_b;
            end
            7'h6f: begin
                wr        = 1'b1;
                exp_wdata = model_pc + 32'd4;
                exp_next  = model_pc + imm_j;
            end
            default: wr = 1'b0;
        endcase
        check_value("o_imem_raddr", o_imem_raddr, model_pc);
        check_value("o_retire.valid", retire.valid, 32'd1);
        check_value("o_retire.inst", retire.inst, inst);
        check_value("o_retire.pc", retire.pc, model_pc);
        check_value("o_retire.next_pc", retire.next_pc, exp_next);
        check_value("o_retire.rd_waddr", retire.rd_waddr, wr ? inst[11:7] : 5'd0);
        if (wr && inst[11:7] != 5'd0) begin
            check_value("o_retire.rd_wdata", retire.rd_wdata, exp_wdata);
            model_regs[inst[11:7]] = exp_wdata;
        end
        model_pc = exp_next;
    endtask

    task automatic run_test(input int test_id, input string name);
        int          errors_before;
        logic [31:0] inst;
        errors_before = error_count;
        if (test_id == 0) begin
            // retire must stay invalid for the whole reset
            repeat (reset_cycles) begin
                @(negedge i_clk);
                check_value("o_retire.valid", retire.valid, 32'd0);
            end
        end
        for (int n = 0; n < inst_per_test; n++) begin
            inst = make_inst(test_id);
            @(posedge i_clk);
            i_reset      <= 1'b0;
            i_imem_rdata <= inst;
            @(negedge i_clk);
            step_model(inst);
        end
        $display("%s: %0d instructions, %0d errors", name, inst_per_test,
                 error_count - errors_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        i_reset      = 1'b1;
        i_imem_rdata = '0;
        rng_state    = 32'he2bf_d7dd;
        cycle_count  = 0;
        check_count  = 0;
        error_count  = 0;
        // the model starts where reset leaves the hart, so the first pc check
        // covers the reset address and early reads cover the cleared registers
        model_pc = `HART_RESET_ADDR;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        run_test(0, "reset");
        run_test(1, "r-type alu");
        run_test(2, "i-type alu and lui");
        run_test(3, "branches");
        run_test(4, "jal");
        run_test(5, "unsupported opcodes");
        $display("%0d tests, %0d checks, %0d errors", num_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
